/* logic/fetchPkg.sv */
// Fetch front end definitions
package fetchPkg;

  //////////////////////////////
  // Constants
  //////////////////////////////

  // Address and PC width
  localparam int XLEN = 32;

  // Instruction cache line size in bytes
  localparam int LINE_BYTES = 16;

  // Byte offset bits within one line
  localparam int LINE_OFFSET = $clog2(LINE_BYTES);

  // Width of one instruction parcel
  localparam int HALF_BITS = 16;

  // First fetch address after reset
  localparam logic [XLEN-1:0] RESET_PC = '0;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Two parcels of one memory word, upper one first
  typedef struct packed {
    logic [HALF_BITS-1:0] hi;
    logic [HALF_BITS-1:0] lo;
  } halvesT;

  // One fetched word, either a full instruction or two parcels
  typedef union packed {
    logic [2*HALF_BITS-1:0] raw;
    halvesT                 halves;
  } fetchWordU;

  // Redirect strobe and its halfword-aligned target
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirectT;

  // Fetch to decode packet
  typedef struct packed {
    logic [XLEN-1:0] pc;
    fetchWordU       instr;
    logic            compressed;
  } fetchPacketT;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Compressed unless both low opcode bits are set
  function automatic logic isCompressed(input logic [HALF_BITS-1:0] half);
    return half[1:0] != 2'b11;
  endfunction

  // PC plus 2 built from PC plus 4, no extra adder
  function automatic logic [XLEN-1:0] nextHalfword(input logic [XLEN-1:0] pc,
                                                   input logic [XLEN-1:0] pcPlus4);
    // Odd halfword rolls into the next word
    return pc[1] ? {pcPlus4[XLEN-1:2], 2'b00} : {pc[XLEN-1:2], 2'b10};
  endfunction

endpackage

/* logic/pcGen.sv */
// Fetch PC generator
`timescale 1ns/100ps

module pcGen (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     advance,
  input  logic                     instrCompressed,
  input  fetchPkg::redirectT       redirect,
  output logic [fetchPkg::XLEN-1:0] pc,
  output logic [fetchPkg::XLEN-1:0] pcPlus4
);

  import fetchPkg::*;

  // Sequential step candidates
  logic [XLEN-1:0] pcPlus2;
  logic [XLEN-1:0] pcStep;

  //////////////////////////////
  // Next PC
  //////////////////////////////

  // One adder for the 4 byte step
  assign pcPlus4 = pc + XLEN'(4);

  // The 2 byte step reuses the upper bits of pcPlus4
  assign pcPlus2 = nextHalfword(pc, pcPlus4);

  // Step size follows the decoded length
  always_comb begin
    if (instrCompressed) begin
      pcStep = pcPlus2;
    end else begin
      pcStep = pcPlus4;
    end
  end

  //////////////////////////////
  // PC register
  //////////////////////////////

  // Redirect wins over a sequential step
  // Hold when the current word is not consumed
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (redirect.valid) begin
      pc <= redirect.target;
    end else if (advance) begin
      pc <= pcStep;
    end
  end

endmodule

/* logic/fetchSpill.sv */
// Line-crossing fetch spill
`timescale 1ns/100ps

module fetchSpill (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [fetchPkg::XLEN-1:0] pc,
  input  logic [fetchPkg::XLEN-1:0] pcPlus4,
  input  fetchPkg::fetchWordU       memData,
  input  logic                      memStall,
  input  logic                      decodeStall,
  input  logic                      flush,
  output logic [fetchPkg::XLEN-1:0] fetchAddr,
  output logic                      spillNext,
  output fetchPkg::fetchWordU       mergedWord
);

  import fetchPkg::*;

  // Ready fetches at pc, spill fetches the second parcel
  typedef enum logic {
    stateReady,
    stateSpill
  } spillStateT;

  spillStateT             state;
  spillStateT             stateNext;
  logic [XLEN-1:0]        pcPlus2Reg;
  logic                   atLineEnd;
  logic                   takeSpill;
  logic                   saveFirst;
  logic [HALF_BITS-1:0]   firstHalf;

  //////////////////////////////
  // Spill detection
  //////////////////////////////

  // Last halfword of a line, all offset bits above bit 0 set
  assign atLineEnd = &pc[LINE_OFFSET-1:1];

  // Only a full-length instruction needs the next line
  // Wait for memory and decode before starting
  assign takeSpill = atLineEnd & ~memStall & ~decodeStall &
                     ~isCompressed(memData.halves.lo);

  //////////////////////////////
  // Spill FSM
  //////////////////////////////

  always_comb begin
    case (state)
      stateReady: begin
        if (takeSpill) begin
          stateNext = stateSpill;
        end else begin
          stateNext = stateReady;
        end
      end
      stateSpill: begin
        // Second parcel must arrive and be taken by decode
        if (memStall || decodeStall) begin
          stateNext = stateSpill;
        end else begin
          stateNext = stateReady;
        end
      end
      default: stateNext = stateReady;
    endcase
  end

  // Redirect drops a half-done spill
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      state <= stateReady;
    end else begin
      state <= stateNext;
    end
  end

  // Keeps the PC from stepping until the merge is done
  assign spillNext = (stateNext == stateSpill);

  //////////////////////////////
  // Fetch address
  //////////////////////////////

  // PC is stable across the spill, so the registered copy is enough
  always_ff @(posedge clk) begin
    pcPlus2Reg <= nextHalfword(pc, pcPlus4);
  end

  assign fetchAddr = (state == stateSpill) ? pcPlus2Reg : pc;

  //////////////////////////////
  // Merge
  //////////////////////////////

  // First parcel saved on the cycle the FSM leaves ready
  assign saveFirst = (state == stateReady) & takeSpill & ~flush;

  always_ff @(posedge clk) begin
    if (saveFirst) begin
      firstHalf <= memData.halves.lo;
    end
  end

  // New low parcel goes above the saved one
  always_comb begin
    if (state == stateSpill) begin
      mergedWord.halves.hi = memData.halves.lo;
      mergedWord.halves.lo = firstHalf;
    end else begin
      mergedWord = memData;
    end
  end

endmodule

/* logic/fetchOutStage.sv */
// Fetch output stage
`timescale 1ns/100ps

module fetchOutStage (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [fetchPkg::XLEN-1:0] pc,
  input  fetchPkg::fetchWordU       mergedWord,
  input  logic                      memStall,
  input  logic                      decodeStall,
  input  logic                      spillNext,
  input  logic                      flush,
  output logic                      advance,
  output logic                      instrCompressed,
  output logic                      outValid,
  output fetchPkg::fetchPacketT     outPacket
);

  import fetchPkg::*;

  //////////////////////////////
  // Length decode
  //////////////////////////////

  // Low parcel of the merged word always holds the opcode bits
  assign instrCompressed = isCompressed(mergedWord.halves.lo);

  // Word is consumed when memory answered, decode is free
  // and no second parcel is still pending
  assign advance = ~memStall & ~decodeStall & ~spillNext;

  //////////////////////////////
  // Decode register
  //////////////////////////////

  // Payload loads only with a consumed word
  always_ff @(posedge clk) begin
    if (advance) begin
      outPacket.pc         <= pc;
      outPacket.instr      <= mergedWord;
      outPacket.compressed <= instrCompressed;
    end
  end

  // Valid flag
  // Held under decode stall, otherwise follows advance
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      outValid <= 1'b0;
    end else if (!decodeStall) begin
      outValid <= advance;
    end
  end

endmodule

/* logic/fetchTop.sv */
// Instruction fetch front end
`timescale 1ns/100ps

module fetchTop (
  input  logic                      clk,
  input  logic                      rst,
  input  fetchPkg::fetchWordU       memData,
  input  logic                      memStall,
  input  logic                      decodeStall,
  input  fetchPkg::redirectT        redirect,
  output logic [fetchPkg::XLEN-1:0] fetchAddr,
  output logic                      outValid,
  output fetchPkg::fetchPacketT     outPacket
);

  import fetchPkg::*;

  // PC generator outputs
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pcPlus4;

  // Spill unit outputs
  logic            spillNext;
  fetchWordU       mergedWord;

  // Output stage feedback
  logic            advance;
  logic            instrCompressed;

  //////////////////////////////
  // PC generator
  //////////////////////////////

  pcGen i_pcGen (
    .clk             (clk),
    .rst             (rst),
    .advance         (advance),
    .instrCompressed (instrCompressed),
    .redirect        (redirect),
    .pc              (pc),
    .pcPlus4         (pcPlus4)
  );

  //////////////////////////////
  // Spill unit
  //////////////////////////////

  // Redirect strobe doubles as flush
  fetchSpill i_fetchSpill (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .pcPlus4     (pcPlus4),
    .memData     (memData),
    .memStall    (memStall),
    .decodeStall (decodeStall),
    .flush       (redirect.valid),
    .fetchAddr   (fetchAddr),
    .spillNext   (spillNext),
    .mergedWord  (mergedWord)
  );

  //////////////////////////////
  // Output stage
  //////////////////////////////

  fetchOutStage i_fetchOutStage (
    .clk             (clk),
    .rst             (rst),
    .pc              (pc),
    .mergedWord      (mergedWord),
    .memStall        (memStall),
    .decodeStall     (decodeStall),
    .spillNext       (spillNext),
    .flush           (redirect.valid),
    .advance         (advance),
    .instrCompressed (instrCompressed),
    .outValid        (outValid),
    .outPacket       (outPacket)
  );

endmodule

/* verification/fetchTb.sv */
// Fetch front end testbench
`timescale 1ns/100ps

module fetchTb;

  import fetchPkg::*;

  //////////////////////////////
  // Constants and signals
  //////////////////////////////

  // Word map of the test data file
  localparam int TEST_WORDS   = 512;
  localparam int IMAGE_HALVES = 256;
  localparam int HDR_BASE     = 'h100;
  localparam int REC_BASE     = 'h110;
  localparam int WIN_BASE     = 'h130;

  // Cycles without a packet before giving up
  localparam int IDLE_LIMIT = 64;
  localparam logic [31:0] LFSR_SEED = 32'd77279;

  logic            clk = 1'b0;
  logic            rst;
  fetchWordU       memData;
  logic            memStall;
  logic            decodeStall;
  redirectT        redirect;
  logic [XLEN-1:0] fetchAddr;
  logic            outValid;
  fetchPacketT     outPacket;

  // Raw file contents, then the three tables split out of it
  logic [63:0]     tests [0:TEST_WORDS-1];
  logic [15:0]     image [0:IMAGE_HALVES-1];
  int              recCount [0:7];
  int              recDelay [0:7];
  logic [31:0]     recTarget [0:7];
  logic [63:0]     recName [0:7];
  int              winStart [0:7];
  int              winLen [0:7];
  int              numRecs;
  int              totalPackets;
  int              numWindows;

  // Run state
  logic [31:0]     lfsrState;
  logic [XLEN-1:0] modelPc;
  logic [63:0]     testName;
  fetchPacketT     heldPacket;
  logic            holding;
  logic            addrCheck;
  logic [XLEN-1:0] expAddr;
  logic            timedOut;
  int              recIdx;
  int              recWait;
  int              delivered;
  int              idleCycles;
  int              cycle;
  int              valueErrors;
  int              otherErrors;

  always #20 clk = ~clk;

  fetchTop i_fetchTop (
    .clk         (clk),
    .rst         (rst),
    .memData     (memData),
    .memStall    (memStall),
    .decodeStall (decodeStall),
    .redirect    (redirect),
    .fetchAddr   (fetchAddr),
    .outValid    (outValid),
    .outPacket   (outPacket)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int n = 0; n < count; n++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic logic inStallWindow(input int at);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < numWindows; w++) begin
      if (at >= winStart[w] && at < winStart[w] + winLen[w]) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Fill first, so unlisted halfwords still read as something known
  task automatic loadTests();
    for (int i = 0; i < TEST_WORDS; i++) begin
      tests[i] = {48'h0, 16'(i) ^ 16'hc3a5};
    end
    $readmemh("verification/fetch_tests.dat", tests);
    for (int i = 0; i < IMAGE_HALVES; i++) begin
      image[i] = tests[i][15:0];
    end
    numRecs = tests[HDR_BASE][31:0];
    totalPackets = tests[HDR_BASE+1][31:0];
    numWindows = tests[HDR_BASE+2][31:0];
    // Record layout is count, delay, target, name
    for (int r = 0; r < numRecs; r++) begin
      recCount[r] = tests[REC_BASE+4*r][31:0];
      recDelay[r] = tests[REC_BASE+4*r+1][31:0];
      recTarget[r] = tests[REC_BASE+4*r+2][31:0];
      recName[r] = tests[REC_BASE+4*r+3];
    end
    for (int w = 0; w < numWindows; w++) begin
      winStart[w] = tests[WIN_BASE+2*w][31:0];
      winLen[w] = tests[WIN_BASE+2*w+1][31:0];
    end
  endtask

  // Reference walk takes 32 bits when both low bits are set, else 16
  task automatic nextExpected(output fetchPacketT exp);
    logic [7:0]  idx;
    logic [15:0] lo;
    idx = modelPc[8:1];
    lo = image[idx];
    exp.pc = modelPc;
    exp.instr.raw = {image[idx + 8'd1], lo};
    exp.compressed = (lo[1:0] != 2'b11);
    modelPc = modelPc + (exp.compressed ? 32'd2 : 32'd4);
  endtask

  // Instruction cache model with garbage on stalled cycles
  task automatic driveMemory();
    logic [7:0]  idx;
    logic [31:0] garbage;
    idx = fetchAddr[8:1];
    memStall = (takeBits(2) == 32'd3);
    if (memStall) begin
      memData.raw = takeBits(32);
    end else if (&fetchAddr[LINE_OFFSET-1:1]) begin
      // Only the low half is valid at the end of a line
      garbage = takeBits(16);
      memData.raw = {garbage[15:0], image[idx]};
    end else begin
      memData.raw = {image[idx + 8'd1], image[idx]};
    end
  endtask

  //////////////////////////////
  // Checks and stimulus
  //////////////////////////////

  task automatic checkOutputs();
    fetchPacketT exp;
    fetchPacketT seen;
    logic [31:0] mask;
    // First fetch after reset or a redirect goes to the new PC
    if (addrCheck) begin
      if (fetchAddr !== expAddr) begin
        $display("FAIL %s fetchAddr: expected %h actual %h", testName, expAddr, fetchAddr);
        valueErrors++;
      end
      addrCheck = 1'b0;
    end
    if (outValid === 1'b1) begin
      idleCycles = 0;
      if (holding) begin
        // Decode stalled last cycle, so the same packet must still be there
        mask = heldPacket.compressed ? 32'h0000_ffff : 32'hffff_ffff;
        seen = outPacket;
        seen.instr.raw = outPacket.instr.raw & mask;
        if (seen !== heldPacket) begin
          $display("FAIL %s held packet: expected %h actual %h",
                   testName, heldPacket, seen);
          valueErrors++;
        end
      end else begin
        nextExpected(exp);
        // Upper half of a compressed word is don't care
        mask = exp.compressed ? 32'h0000_ffff : 32'hffff_ffff;
        if (outPacket.pc !== exp.pc) begin
          $display("FAIL %s pc: expected %h actual %h", testName, exp.pc, outPacket.pc);
          valueErrors++;
        end
        if ((outPacket.instr.raw & mask) !== (exp.instr.raw & mask)) begin
          $display("FAIL %s instr at %h: expected %h actual %h",
                   testName, exp.pc, exp.instr.raw & mask, outPacket.instr.raw & mask);
          valueErrors++;
        end
        if (outPacket.compressed !== exp.compressed) begin
          $display("FAIL %s compressed at %h: expected %b actual %b",
                   testName, exp.pc, exp.compressed, outPacket.compressed);
          valueErrors++;
        end
        heldPacket = exp;
        heldPacket.instr.raw = exp.instr.raw & mask;
        delivered++;
      end
    end else begin
      if (holding) begin
        $display("Packet was dropped while decode was stalled in %s", testName);
        otherErrors++;
      end
      idleCycles++;
      if (idleCycles > IDLE_LIMIT) begin
        $display("No instruction arrived within %0d cycles in %s", IDLE_LIMIT, testName);
        otherErrors++;
        timedOut = 1'b1;
      end
    end
  endtask

  task automatic driveInputs();
    logic fire;
    fire = 1'b0;
    redirect = '0;
    // Strobe once the packet count is reached and the delay ran out
    if (recIdx < numRecs && delivered >= recCount[recIdx]) begin
      if (recWait == recDelay[recIdx]) begin
        fire = 1'b1;
        redirect.valid = 1'b1;
        redirect.target = recTarget[recIdx];
        modelPc = recTarget[recIdx];
        addrCheck = 1'b1;
        expAddr = recTarget[recIdx];
        testName = recName[recIdx];
        recIdx++;
        recWait = 0;
      end else begin
        recWait++;
      end
    end
    // Decode never stalls in a redirect cycle
    decodeStall = inStallWindow(cycle) && !fire;
    holding = outValid && decodeStall;
    driveMemory();
    cycle++;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst = 1'b1;
    memData = '0;
    memStall = 1'b0;
    decodeStall = 1'b0;
    redirect = '0;
    lfsrState = LFSR_SEED;
    modelPc = RESET_PC;
    testName = "startup ";
    heldPacket = '0;
    holding = 1'b0;
    addrCheck = 1'b1;
    expAddr = RESET_PC;
    timedOut = 1'b0;
    recIdx = 0;
    recWait = 0;
    delivered = 0;
    idleCycles = 0;
    cycle = 0;
    valueErrors = 0;
    otherErrors = 0;
    loadTests();
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // Sample and drive mid cycle away from the rising edge
    while (delivered < totalPackets && !timedOut) begin
      checkOutputs();
      driveInputs();
      @(negedge clk);
    end
    $display("Checked %0d of %0d packets, value errors %0d, other errors %0d",
             delivered, totalPackets, valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verification/fetch_tests.dat */
// Fetch test data, all values hex
// @000 program image, one 16 byte cache line per row, lowest halfword first
@000
0093 0010 0113 0020 0193 0030 0213 0040
0293 0050 0313 0060 0393 0070 0413 0080
// Mixed lengths, compressed parcel at the line end at 2e
4501 0593 0010 0505 8082 0613 0020 4685
0713 0030 4709 0793 0040 47a1 0813 0050
// Full instructions at 4e 5e 6e 7e cross into the next line
48a1 0893 0060 4905 0913 0070 4985 0993
0080 0a13 0090 4a05 0a93 00a0 4a85 0b13
00b0 4b05 0b93 00c0 4b85 0c13 00d0 0c93
00e0 4c05 0d13 00f0 4c85 0d93 0100 0e13
0110 4d05 0e93 0120 4d85 0f13 0130 4e05
// @100 header: redirect records, packets to check, stall windows
@100
4 2f 4
// @110 redirect records: packet count, delay cycles, target, name in ASCII
@110
// Start of the stream
0 0 00 7365713332626974
// Drops 18 and 1c still in flight
6 0 20 6d697865646c656e
// Odd halfword target
17 0 56 6f646468616c6677
// One cycle after 6a, while 6e is in its spill
1f 1 4e 6d69647370696c6c
// @130 decode stall windows: start cycle, length in cycles
@130
0a 4
25 6
48 3
60 5

/* fetchTop.f */
logic/fetchPkg.sv
logic/pcGen.sv
logic/fetchSpill.sv
logic/fetchOutStage.sv
logic/fetchTop.sv
verification/fetchTb.sv

/* Makefile */
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetchTb
FILELIST  ?= fetchTop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
